// ==== execute.f ====
+incdir+test
verilog/cpu_types_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/lane_exec.sv
verilog/branch_unit.sv
verilog/mul_div_unit.sv
verilog/exec_ctrl.sv
verilog/execute.sv
test/tb_execute.sv

// ==== test/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

typedef issue_data_t [1:0]   issue_pair_t;
typedef execute_data_t [1:0] exec_pair_t;

function automatic word_t model_alu(input word_t a, input word_t b, input alufunc_t f,
                                    output logic ovf);
    longint s;
    ovf = 1'b0;
    case (f)
        ADD, SUB: begin
            if (f == ADD) begin
                s = longint'(signed'(a)) + longint'(signed'(b));
            end else begin
                s = longint'(signed'(a)) - longint'(signed'(b));
            end
            // result does not fit in 32 signed bits
            ovf = s[32] != s[31];
            return word_t'(s);
        end
        ADDU: return a + b;
        SUBU: return a - b;
        AND:  return a & b;
        OR:   return a | b;
        XOR:  return a ^ b;
        NOR:  return ~(a | b);
        SLT:  return (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
        SLTU: return (a < b) ? 32'd1 : 32'd0;
        SLL:  return b << a[4:0];
        SRL:  return b >> a[4:0];
        SRA:  return word_t'(signed'(b) >>> a[4:0]);
        LUI:  return b << 16;
        default: return '0;
    endcase
endfunction

function automatic dword_t model_hilo(input op_t op, input word_t a, input word_t b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = longint'(signed'(a));
    sb = longint'(signed'(b));
    case (op)
        MULT:  return dword_t'(sa * sb);
        MULTU: return {32'b0, a} * {32'b0, b};
        DIV: begin
            // quotient all ones on magnitudes, then the sign fix
            if (b == '0) begin
                return {a, (a[31] ? 32'd1 : 32'hffff_ffff)};
            end
            q = sa / sb;
            r = sa % sb;
            return {word_t'(r), word_t'(q)};
        end
        DIVU: begin
            if (b == '0) begin
                return {a, 32'hffff_ffff};
            end
            return {a % b, a / b};
        end
        default: return '0;
    endcase
endfunction

function automatic word_t model_branch(input issue_data_t d, output logic taken);
    logic  cond;
    int    sa;
    word_t slot;
    sa   = signed'(d.rd1);
    slot = d.pc + 32'd4;
    case (d.ctl.branch_type)
        BEQ:     cond = d.rd1 == d.rd2;
        BNE:     cond = d.rd1 != d.rd2;
        BLEZ:    cond = sa <= 0;
        BGTZ:    cond = sa > 0;
        BLTZ:    cond = sa < 0;
        BGEZ:    cond = sa >= 0;
        default: cond = 1'b0;
    endcase
    taken = d.ctl.jump || d.ctl.jr || (d.ctl.branch && cond);
    if (d.ctl.branch) begin
        return slot + (32'(signed'(d.imm)) << 2);
    end
    if (d.ctl.jr) begin
        return d.rd1;
    end
    if (d.ctl.jump) begin
        return {slot[31:28], d.raw_instr[25:0], 2'b00};
    end
    return '0;
endfunction

function automatic exec_pair_t expect_pair(input issue_pair_t p);
    exec_pair_t e;
    word_t      a;
    word_t      b;
    word_t      res;
    logic       ovf;
    logic       mis;
    logic       taken;
    logic [1:0] lane_ovf;
    e = '0;
    for (int i = 0; i < 2; i++) begin
        a = p[i].ctl.shamt_valid ? 32'(p[i].raw_instr[10:6]) : p[i].rd1;
        if (p[i].ctl.alusrc == IMM) begin
            b = p[i].ctl.zeroext ? 32'(p[i].imm) : 32'(signed'(p[i].imm));
        end else begin
            b = p[i].rd2;
        end
        res = model_alu(a, b, p[i].ctl.alufunc, ovf);
        mis = (res % (32'd1 << p[i].ctl.msize)) != 0;
        lane_ovf[i] = ovf;
        e[i].valid   = p[i].valid;
        e[i].pc      = p[i].pc;
        e[i].alu_out = res;
        e[i].srca    = p[i].rd1;
        e[i].srcb    = p[i].rd2;
        e[i].rdst    = p[i].rdst;
        e[i].is_slot = p[i].is_slot;
        e[i].ctl     = p[i].ctl;
        if (ovf) begin
            e[i].cp0_ctl.exc            = 1'b1;
            e[i].cp0_ctl.etype.overflow = 1'b1;
        end else if (mis && p[i].ctl.memwrite) begin
            e[i].cp0_ctl.exc         = 1'b1;
            e[i].cp0_ctl.etype.adesD = 1'b1;
            e[i].cp0_ctl.vaddr       = res;
            e[i].ctl.memwrite        = 1'b0;
        end else if (mis && p[i].ctl.memtoreg) begin
            e[i].cp0_ctl.exc         = 1'b1;
            e[i].cp0_ctl.etype.adelD = 1'b1;
            e[i].cp0_ctl.vaddr       = res;
            e[i].ctl.memtoreg        = 1'b0;
        end
        if (p[i].ctl.op != OP_NONE) begin
            e[i].hilo = model_hilo(p[i].ctl.op, p[i].rd1, p[i].rd2);
        end
    end
    e[1].target       = model_branch(p[1], taken);
    e[1].branch_taken = taken;
    if (p[1].ctl.is_link) begin
        e[1].alu_out = p[1].pc + 32'd8;
    end
    if (e[1].cp0_ctl.exc) begin
        e[0].ctl.memwrite = 1'b0;
        e[0].ctl.memtoreg = 1'b0;
    end
    if (lane_ovf[1]) begin
        e[0].valid = 1'b0;
    end
    return e;
endfunction

`endif

// ==== test/tb_execute.sv ====
`timescale 1ns/1ns

module tb_execute import cpu_types_pkg::*, pipe_pkg::*; ();

    localparam int NUM_PAIRS    = 400;
    localparam int ACCEPT_LIMIT = 200;
    localparam int DRAIN_LIMIT  = 400;

    `include "exec_model.svh"

    logic                clk;
    logic                arst_n_i;
    logic                in_valid_i;
    issue_data_t [1:0]   in_data_i;
    logic                in_ready_o;
    logic                out_valid_o;
    execute_data_t [1:0] out_data_o;
    logic                out_ready_i;

    logic [31:0]         rng_state;
    logic [31:0]         rnd;
    issue_pair_t         pairs [NUM_PAIRS];
    logic                gaps [NUM_PAIRS];
    exec_pair_t          exp_q [$];
    exec_pair_t          stall_data;
    logic                stalled;
    logic                abort;
    int                  errors;
    int                  n_in;
    int                  n_out;

    execute #(
        .MD_BITS_PER_CYCLE (1)
    ) uut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic issue_data_t gen_lane(input logic older);
        issue_data_t d;
        logic [31:0] r;
        logic [31:0] r2;
        d  = '0;
        r  = next_rand();
        r2 = next_rand();
        d.valid           = older || (r[1:0] != 2'd0);
        d.ctl.alufunc     = alufunc_t'(r[7:4] % 14);
        d.ctl.alusrc      = alusrc_t'(r[8]);
        d.ctl.zeroext     = r[9];
        d.ctl.shamt_valid = r[10] && (d.ctl.alufunc inside {SLL, SRL, SRA});
        d.ctl.msize       = msize_t'(r[12:11] % 3);
        d.ctl.memtoreg    = r[15:13] == 3'd0;
        d.ctl.memwrite    = r[15:13] == 3'd1;
        d.rdst            = r[20:16];
        d.pc              = next_rand() & 32'hffff_fffc;
        d.raw_instr       = next_rand();
        d.rd1             = next_rand();
        d.imm             = r2[31:16];
        // equal operands and zero divisors now and then
        if (r2[2:0] == 3'd0) begin
            d.rd2 = '0;
        end else if (r2[5:4] == 2'd0) begin
            d.rd2 = d.rd1;
        end else begin
            d.rd2 = next_rand();
        end
        return d;
    endfunction

    function automatic issue_pair_t gen_pair();
        issue_pair_t p;
        logic [31:0] r;
        p[1] = gen_lane(1'b1);
        p[0] = gen_lane(1'b0);
        r    = next_rand();
        case (r[2:0])
            3'd1:    p[1].ctl.branch = 1'b1;
            3'd2:    p[1].ctl.jump = 1'b1;
            3'd3:    p[1].ctl.jr = 1'b1;
            default: p[1].ctl.branch = 1'b0;
        endcase
        p[1].ctl.branch_type = branch_t'(r[6:3] % 6);
        p[1].ctl.is_link     = r[7];
        if (p[1].ctl.is_link) begin
            p[1].ctl.memtoreg = 1'b0;
            p[1].ctl.memwrite = 1'b0;
        end
        p[0].is_slot = p[1].ctl.branch || p[1].ctl.jump || p[1].ctl.jr;
        // at most one hi/lo op per pair
        if (r[9:8] == 2'd0) begin
            p[r[10]].ctl.op = op_t'(1 + r[12:11]);
        end
        return p;
    endfunction

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!in_ready_o && cycles < ACCEPT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (in_ready_o) else begin
            $display("timeout: in_ready_o stayed low for %0d cycles", cycles);
            errors++;
            abort = 1'b1;
        end
    endtask

    task automatic check_output();
        exec_pair_t exp;
        assert (exp_q.size() != 0) else begin
            $display("output transfer seen with no pair outstanding");
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            for (int i = 0; i < 2; i++) begin
                assert (out_data_o[i] === exp[i]) else begin
                    $display("FAILED out_data_o[%0d] pair %0d: got %h expected %h",
                             i, n_out, out_data_o[i], exp[i]);
                    errors++;
                end
            end
        end
        n_out++;
    endtask

    // scoreboard, stall check and random back-pressure at the output
    always @(posedge clk) begin
        if (arst_n_i) begin
            if (stalled) begin
                assert (out_valid_o && out_data_o === stall_data) else begin
                    $display("FAILED out_data_o while stalled: valid %h got %h held %h",
                             out_valid_o, out_data_o, stall_data);
                    errors++;
                end
            end
            stalled    = out_valid_o && !out_ready_i;
            stall_data = out_data_o;
            if (out_valid_o && out_ready_i) begin
                check_output();
            end
            rnd = next_rand();
            out_ready_i <= rnd[2:0] > 3'd2;
        end
    end

    initial begin : driver
        int cycles;
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        in_valid_i  = 1'b0;
        in_data_i   = '0;
        out_ready_i = 1'b0;
        rng_state   = 32'h4686;
        stalled     = 1'b0;
        abort       = 1'b0;
        errors      = 0;
        n_in        = 0;
        n_out       = 0;
        for (int n = 0; n < NUM_PAIRS; n++) begin
            pairs[n] = gen_pair();
            gaps[n]  = next_rand() % 5 == 0;
        end
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int n = 0; n < NUM_PAIRS && !abort; n++) begin
            if (gaps[n]) begin
                in_valid_i <= 1'b0;
                @(posedge clk);
            end
            in_valid_i <= 1'b1;
            in_data_i  <= pairs[n];
            wait_accept();
            if (!abort) begin
                exp_q.push_back(expect_pair(pairs[n]));
                n_in++;
            end
        end
        in_valid_i <= 1'b0;
        cycles = 0;
        while (!abort && exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        assert (abort || exp_q.size() == 0) else begin
            $display("timeout: %0d pairs never left the stage", exp_q.size());
            errors++;
        end
        assert (abort || n_out == n_in) else begin
            $display("pair count mismatch: %0d accepted, %0d delivered", n_in, n_out);
            errors++;
        end
        $display("pairs in %0d, pairs out %0d, errors %0d", n_in, n_out, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns

module alu import cpu_types_pkg::*; (
    input  word_t    a_i,
    input  word_t    b_i,
    input  alufunc_t alufunc_i,
    output word_t    c_o,
    output logic     overflow_o
);

    word_t sum;
    word_t diff;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    always_comb begin
        c_o        = '0;
        overflow_o = 1'b0;
        case (alufunc_i)
            ADD: begin
                c_o        = sum;
                // same signs in, other sign out
                overflow_o = (a_i[31] == b_i[31]) && (sum[31] != a_i[31]);
            end
            ADDU: c_o = sum;
            SUB: begin
                c_o        = diff;
                overflow_o = (a_i[31] != b_i[31]) && (diff[31] != a_i[31]);
            end
            SUBU: c_o = diff;
            AND:  c_o = a_i & b_i;
            OR:   c_o = a_i | b_i;
            XOR:  c_o = a_i ^ b_i;
            NOR:  c_o = ~(a_i | b_i);
            SLT:  c_o = {31'b0, $signed(a_i) < $signed(b_i)};
            SLTU: c_o = {31'b0, a_i < b_i};
            // shift value in b, amount in a
            SLL:  c_o = b_i << a_i[4:0];
            SRL:  c_o = b_i >> a_i[4:0];
            SRA:  c_o = $signed(b_i) >>> a_i[4:0];
            LUI:  c_o = {b_i[15:0], 16'b0};
            default: c_o = '0;
        endcase
    end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit import cpu_types_pkg::*, pipe_pkg::*; (
    input  issue_data_t data_i,
    output word_t       target_o,
    output logic        branch_taken_o,
    output word_t       link_addr_o
);

    word_t slot_pc;
    word_t offset;
    logic  cond;

    assign slot_pc     = data_i.pc + 32'd4;
    assign offset      = {{14{data_i.imm[15]}}, data_i.imm, 2'b00};
    assign link_addr_o = data_i.pc + 32'd8;

    always_comb begin
        case (data_i.ctl.branch_type)
            BEQ:     cond = data_i.rd1 == data_i.rd2;
            BNE:     cond = data_i.rd1 != data_i.rd2;
            BLEZ:    cond = data_i.rd1[31] || (data_i.rd1 == '0);
            BGTZ:    cond = !data_i.rd1[31] && (data_i.rd1 != '0);
            BLTZ:    cond = data_i.rd1[31];
            BGEZ:    cond = !data_i.rd1[31];
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        target_o = '0;
        if (data_i.ctl.branch) begin
            target_o = slot_pc + offset;
        end else if (data_i.ctl.jr) begin
            target_o = data_i.rd1;
        end else if (data_i.ctl.jump) begin
            // region of the delay slot
            target_o = {slot_pc[31:28], data_i.raw_instr[25:0], 2'b00};
        end
    end

    assign branch_taken_o = data_i.ctl.jump || data_i.ctl.jr || (data_i.ctl.branch && cond);

endmodule

// ==== verilog/cpu_types_pkg.sv ====
package cpu_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  shamt_t;

    typedef enum logic [3:0] {
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        LUI
    } alufunc_t;

    typedef enum logic {
        REGB,
        IMM
    } alusrc_t;

    typedef enum logic [2:0] {
        BEQ, BNE, BLEZ, BGTZ, BLTZ, BGEZ
    } branch_t;

    // hi/lo producing ops only
    typedef enum logic [2:0] {
        OP_NONE, MULT, MULTU, DIV, DIVU
    } op_t;

    typedef enum logic [1:0] {
        MSIZE1, MSIZE2, MSIZE4
    } msize_t;

    typedef struct packed {
        logic overflow;
        logic adelD;
        logic adesD;
    } etype_t;

endpackage

// ==== verilog/exec_ctrl.sv ====
`timescale 1ns/1ns

module exec_ctrl import cpu_types_pkg::*, pipe_pkg::*; #(
    parameter int MD_BITS_PER_CYCLE = 1
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  issue_data_t [1:0]   in_data_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    output execute_data_t [1:0] out_data_o,
    output issue_data_t [1:0]   held_o,
    input  word_t [1:0]         alu_out_i,
    input  logic [1:0]          overflow_i,
    input  logic [1:0]          load_misalign_i,
    input  logic [1:0]          store_misalign_i,
    input  logic                branch_taken_i,
    input  word_t               target_i,
    input  word_t               link_addr_i,
    output logic                md_start_o,
    output op_t                 md_op_o,
    output word_t               md_a_o,
    output word_t               md_b_o,
    input  logic                md_done_i,
    input  dword_t              md_result_i
);

    localparam int MD_STEPS = 32 / MD_BITS_PER_CYCLE;

    typedef enum logic {IDLE, MD_RUN} state_t;

    state_t              state;
    logic                rst_done;
    logic                in_vld;
    logic                md_fin;
    logic                has_md;
    logic                md_lane;
    logic                pair_ready;
    logic                out_free;
    logic                advance;
    execute_data_t [1:0] nxt;
    execute_data_t [1:0] nxt_q;

    assign md_lane = held_o[1].ctl.op != OP_NONE;
    assign has_md  = md_lane || (held_o[0].ctl.op != OP_NONE);
    assign md_op_o = held_o[md_lane].ctl.op;
    assign md_a_o  = held_o[md_lane].rd1;
    assign md_b_o  = held_o[md_lane].rd2;

    assign md_start_o = (state == IDLE) && in_vld && has_md && !md_fin;

    always_comb begin
        case (state)
            IDLE:    pair_ready = in_vld && (!has_md || md_fin);
            MD_RUN:  pair_ready = md_done_i;
            default: pair_ready = 1'b0;
        endcase
    end

    assign out_free    = !out_valid_o || out_ready_i;
    assign advance     = pair_ready && out_free;
    assign in_ready_o  = rst_done && (state == IDLE) && out_free && (!in_vld || pair_ready);
    assign out_data_o  = nxt_q;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            nxt[i]              = '0;
            nxt[i].valid        = held_o[i].valid;
            nxt[i].pc           = held_o[i].pc;
            nxt[i].alu_out      = alu_out_i[i];
            nxt[i].srca         = held_o[i].rd1;
            nxt[i].srcb         = held_o[i].rd2;
            nxt[i].rdst         = held_o[i].rdst;
            nxt[i].is_slot      = held_o[i].is_slot;
            nxt[i].ctl          = held_o[i].ctl;
            // overflow wins, then store, then load
            if (overflow_i[i]) begin
                nxt[i].cp0_ctl.exc            = 1'b1;
                nxt[i].cp0_ctl.etype.overflow = 1'b1;
            end else if (store_misalign_i[i]) begin
                nxt[i].cp0_ctl.exc         = 1'b1;
                nxt[i].cp0_ctl.etype.adesD = 1'b1;
                nxt[i].cp0_ctl.vaddr       = alu_out_i[i];
                nxt[i].ctl.memwrite        = 1'b0;
            end else if (load_misalign_i[i]) begin
                nxt[i].cp0_ctl.exc         = 1'b1;
                nxt[i].cp0_ctl.etype.adelD = 1'b1;
                nxt[i].cp0_ctl.vaddr       = alu_out_i[i];
                nxt[i].ctl.memtoreg        = 1'b0;
            end
        end
        if (held_o[1].ctl.is_link) begin
            nxt[1].alu_out = link_addr_i;
        end
        nxt[1].target       = target_i;
        nxt[1].branch_taken = branch_taken_i;
        // slot must not touch memory behind a faulting lane 1
        if (nxt[1].cp0_ctl.exc) begin
            nxt[0].ctl.memwrite = 1'b0;
            nxt[0].ctl.memtoreg = 1'b0;
        end
        if (overflow_i[1]) begin
            nxt[0].valid = 1'b0;
        end
        if (has_md) begin
            nxt[md_lane].hilo = md_result_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state       <= IDLE;
            rst_done    <= 1'b0;
            in_vld      <= 1'b0;
            md_fin      <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            rst_done <= 1'b1;
            if (in_valid_i && in_ready_o) begin
                in_vld <= 1'b1;
            end else if (advance) begin
                in_vld <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (md_start_o) begin
                        state <= MD_RUN;
                    end
                    if (advance) begin
                        md_fin <= 1'b0;
                    end
                end
                MD_RUN: begin
                    if (md_done_i) begin
                        state  <= IDLE;
                        md_fin <= !out_free;
                    end
                end
                default: state <= IDLE;
            endcase
            if (advance) begin
                out_valid_o <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            held_o <= in_data_i;
        end
        if (advance) begin
            nxt_q <= nxt;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

    a_single_md: assert property (@(posedge clk) disable iff (!arst_n_i)
        in_valid_i && in_ready_o |->
            !((in_data_i[1].ctl.op != OP_NONE) && (in_data_i[0].ctl.op != OP_NONE)));

    // result comes back a fixed number of cycles after start
    a_md_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        md_start_o |-> ##(MD_STEPS + 1) md_done_i);

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ns

module execute import cpu_types_pkg::*, pipe_pkg::*; #(
    parameter int MD_BITS_PER_CYCLE = 1
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                in_valid_i,
    input  issue_data_t [1:0]   in_data_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output execute_data_t [1:0] out_data_o,
    input  logic                out_ready_i
);

    issue_data_t [1:0] held;
    word_t [1:0]       alu_out;
    logic [1:0]        overflow;
    logic [1:0]        load_mis;
    logic [1:0]        store_mis;
    word_t             target;
    word_t             link_addr;
    logic              branch_taken;
    logic              md_start;
    logic              md_done;
    op_t               md_op;
    word_t             md_a;
    word_t             md_b;
    dword_t            md_result;

    for (genvar i = 0; i < 2; i++) begin : g_lane
        lane_exec u_lane (
            .clk              (clk),
            .arst_n_i         (arst_n_i),
            .data_i           (held[i]),
            .alu_out_o        (alu_out[i]),
            .overflow_o       (overflow[i]),
            .load_misalign_o  (load_mis[i]),
            .store_misalign_o (store_mis[i])
        );
    end

    // branches only ever sit in the older lane
    branch_unit u_branch (
        .data_i         (held[1]),
        .target_o       (target),
        .branch_taken_o (branch_taken),
        .link_addr_o    (link_addr)
    );

    mul_div_unit #(
        .MD_BITS_PER_CYCLE (MD_BITS_PER_CYCLE)
    ) u_md (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .start_i  (md_start),
        .op_i     (md_op),
        .a_i      (md_a),
        .b_i      (md_b),
        .done_o   (md_done),
        .result_o (md_result)
    );

    exec_ctrl #(
        .MD_BITS_PER_CYCLE (MD_BITS_PER_CYCLE)
    ) u_ctrl (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .in_valid_i       (in_valid_i),
        .in_data_i        (in_data_i),
        .in_ready_o       (in_ready_o),
        .out_valid_o      (out_valid_o),
        .out_ready_i      (out_ready_i),
        .out_data_o       (out_data_o),
        .held_o           (held),
        .alu_out_i        (alu_out),
        .overflow_i       (overflow),
        .load_misalign_i  (load_mis),
        .store_misalign_i (store_mis),
        .branch_taken_i   (branch_taken),
        .target_i         (target),
        .link_addr_i      (link_addr),
        .md_start_o       (md_start),
        .md_op_o          (md_op),
        .md_a_o           (md_a),
        .md_b_o           (md_b),
        .md_done_i        (md_done),
        .md_result_i      (md_result)
    );

endmodule

// ==== verilog/lane_exec.sv ====
`timescale 1ns/1ns

module lane_exec import cpu_types_pkg::*, pipe_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  issue_data_t data_i,
    output word_t       alu_out_o,
    output logic        overflow_o,
    output logic        load_misalign_o,
    output logic        store_misalign_o
);

    word_t  op_a;
    word_t  op_b;
    word_t  imm_ext;
    shamt_t shamt;
    logic   misalign;

    assign shamt   = data_i.raw_instr[10:6];
    assign imm_ext = data_i.ctl.zeroext ? {16'b0, data_i.imm}
                                        : {{16{data_i.imm[15]}}, data_i.imm};
    assign op_a    = data_i.ctl.shamt_valid ? {27'b0, shamt} : data_i.rd1;
    assign op_b    = (data_i.ctl.alusrc == IMM) ? imm_ext : data_i.rd2;

    alu u_alu (
        .a_i        (op_a),
        .b_i        (op_b),
        .alufunc_i  (data_i.ctl.alufunc),
        .c_o        (alu_out_o),
        .overflow_o (overflow_o)
    );

    // address comes straight out of the alu
    always_comb begin
        case (data_i.ctl.msize)
            MSIZE2:  misalign = alu_out_o[0];
            MSIZE4:  misalign = |alu_out_o[1:0];
            default: misalign = 1'b0;
        endcase
    end

    assign load_misalign_o  = data_i.ctl.memtoreg && misalign;
    assign store_misalign_o = data_i.ctl.memwrite && misalign;

    a_no_unsigned_ovf: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_i.valid && (data_i.ctl.alufunc inside {ADDU, SUBU}) |-> !overflow_o);

endmodule

// ==== verilog/mul_div_unit.sv ====
`timescale 1ns/1ns

module mul_div_unit import cpu_types_pkg::*; #(
    parameter int MD_BITS_PER_CYCLE = 1
) (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   start_i,
    input  op_t    op_i,
    input  word_t  a_i,
    input  word_t  b_i,
    output logic   done_o,
    output dword_t result_o
);

    localparam int STEPS = 32 / MD_BITS_PER_CYCLE;

    logic        busy;
    logic [5:0]  cnt;
    logic        is_div;
    logic        neg_q;
    logic        neg_r;
    logic        signed_op;
    word_t       mcand;
    word_t       acc;
    word_t       lo;
    word_t       acc_n;
    word_t       lo_n;
    logic [32:0] part;
    dword_t      prod;
    dword_t      res_n;

    assign signed_op = (op_i == MULT) || (op_i == DIV);

    // acc:lo is product for mult, remainder:quotient for div
    always_comb begin
        acc_n = acc;
        lo_n  = lo;
        part  = '0;
        for (int i = 0; i < MD_BITS_PER_CYCLE; i++) begin
            if (is_div) begin
                part = {acc_n, lo_n[31]};
                lo_n = lo_n << 1;
                if (part >= {1'b0, mcand}) begin
                    part    = part - {1'b0, mcand};
                    lo_n[0] = 1'b1;
                end
                acc_n = part[31:0];
            end else begin
                part  = {1'b0, acc_n} + (lo_n[0] ? {1'b0, mcand} : 33'd0);
                lo_n  = {part[0], lo_n[31:1]};
                acc_n = part[32:1];
            end
        end
    end

    assign prod = {acc_n, lo_n};

    // sign fix on the final step
    always_comb begin
        if (is_div) begin
            res_n = {neg_r ? -acc_n : acc_n, neg_q ? -lo_n : lo_n};
        end else begin
            res_n = neg_q ? -prod : prod;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy   <= 1'b0;
            cnt    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                busy <= 1'b1;
                cnt  <= 6'(STEPS);
            end else if (busy) begin
                cnt <= cnt - 6'd1;
                if (cnt == 6'd1) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            is_div <= (op_i == DIV) || (op_i == DIVU);
            neg_q  <= signed_op && (a_i[31] ^ b_i[31]);
            neg_r  <= signed_op && a_i[31];
            lo     <= (signed_op && a_i[31]) ? -a_i : a_i;
            mcand  <= (signed_op && b_i[31]) ? -b_i : b_i;
            acc    <= '0;
        end else if (busy) begin
            acc <= acc_n;
            lo  <= lo_n;
            if (cnt == 6'd1) begin
                result_o <= res_n;
            end
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        start_i |-> !busy);

endmodule

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;
    import cpu_types_pkg::*;

    typedef struct packed {
        alufunc_t alufunc;
        alusrc_t  alusrc;
        logic     zeroext;
        logic     shamt_valid;
        logic     branch;
        branch_t  branch_type;
        logic     jump;
        logic     jr;
        logic     is_link;
        op_t      op;
        logic     memtoreg;
        logic     memwrite;
        msize_t   msize;
    } ctl_t;

    typedef struct packed {
        logic   exc;
        etype_t etype;
        word_t  vaddr;
    } cp0_ctl_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      raw_instr;
        word_t      rd1;
        word_t      rd2;
        imm_t       imm;
        logic [4:0] rdst;
        logic       is_slot;
        ctl_t       ctl;
    } issue_data_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      alu_out;
        word_t      srca;
        word_t      srcb;
        logic [4:0] rdst;
        word_t      target;
        logic       branch_taken;
        logic       is_slot;
        dword_t     hilo;
        ctl_t       ctl;
        cp0_ctl_t   cp0_ctl;
    } execute_data_t;

endpackage
